//--- sim.f
design/overlay_geom_pkg.sv
design/overlay_color_pkg.sv
design/region_decoder.sv
design/glyph_select.sv
design/seg_painter.sv
design/pixel_composer.sv
design/overlay_top.sv
tb/overlay_assert.sv
tb/overlay_tb.sv

//--- Bender.yml
package:
  name: overlay

sources:
  - design/overlay_geom_pkg.sv
  - design/overlay_color_pkg.sv
  - design/region_decoder.sv
  - design/glyph_select.sv
  - design/seg_painter.sv
  - design/pixel_composer.sv
  - design/overlay_top.sv
  - target: test
    files:
      - tb/overlay_assert.sv
      - tb/overlay_tb.sv

//--- tb/overlay_tb.sv
`timescale 1ns/1ps

module overlay_tb;

  localparam logic [31:0] SEED = 32'hdc636fdd;
  localparam int DRAIN_LIMIT = 8;  // cycles to flush the one-stage pipeline
  localparam int TENS_X = 321;
  localparam int ONES_X = 401;
  localparam int CELS_X = 501;
  localparam int GLYPH_Y = 151;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        fire;
  logic        warning;
  logic [3:0]  tens;
  logic [3:0]  ones;
  logic [10:0] x;
  logic [9:0]  y;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;

  logic [11:0] exp_q[$];  // expected {r,g,b} with the oldest first
  string       name_q[$];
  string       test_name;

  overlay_top u_dut (
    .i_clk     (clk),
    .i_arst_n  (arst_n),
    .i_fire    (fire),
    .i_warning (warning),
    .i_tens    (tens),
    .i_ones    (ones),
    .i_x       (x),
    .i_y       (y),
    .o_red     (red),
    .o_green   (green),
    .o_blue    (blue)
  );

  always #20 clk = ~clk;

  function automatic bit in_box(int px, int py, int x0, int y0, int w, int h);
    return (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + h);
  endfunction

  function automatic bit in_rect(int lx, int ly, int x0, int x1, int y0, int y1);
    return (lx >= x0) && (lx <= x1) && (ly >= y0) && (ly <= y1);
  endfunction

  // segment rectangles inside an 80x120 glyph with index 0 as a
  function automatic bit on_seg(int lx, int ly, int seg);
    case (seg)
      0: return in_rect(lx, ly, 10, 69, 10, 19);
      1: return in_rect(lx, ly, 60, 69, 10, 64);
      2: return in_rect(lx, ly, 60, 69, 55, 109);
      3: return in_rect(lx, ly, 10, 69, 100, 109);
      4: return in_rect(lx, ly, 10, 19, 55, 109);
      5: return in_rect(lx, ly, 10, 19, 10, 64);
      default: return in_rect(lx, ly, 10, 69, 55, 64);
    endcase
  endfunction

  // which digits light each segment by listing the ones left dark
  function automatic bit seg_enabled(int d, int seg);
    case (seg)
      0: return !(d == 1 || d == 4);
      1: return !(d == 5 || d == 6);
      2: return d != 2;
      3: return !(d == 1 || d == 4 || d == 7);
      4: return d == 0 || d == 2 || d == 6 || d == 8;
      5: return !(d == 1 || d == 2 || d == 3 || d == 7);
      default: return !(d == 0 || d == 1 || d == 7);
    endcase
  endfunction

  function automatic logic [11:0] expected_rgb(int px, int py, bit f, bit w, int t, int o);
    int  ox;
    int  d;
    int  s;
    bit  cels;
    bit  lit;
    cels = 1'b0;
    d    = 0;
    lit  = 1'b0;
    if (f && in_box(px, py, 521, 1, 120, 120)) return 12'hf00;
    if (w && in_box(px, py, 401, 1, 120, 120)) return 12'hfa0;
    if (in_box(px, py, TENS_X, GLYPH_Y, 80, 120)) begin
      ox = TENS_X;
      d  = t;
    end else if (in_box(px, py, ONES_X, GLYPH_Y, 80, 120)) begin
      ox = ONES_X;
      d  = o;
    end else if (in_box(px, py, CELS_X, GLYPH_Y, 80, 120)) begin
      ox   = CELS_X;
      cels = 1'b1;
    end else begin
      return 12'h000;
    end
    if (!cels && d > 9) return 12'hfff;  // invalid digit fills its window
    for (s = 0; s < 7; s++) begin
      if ((cels ? (s == 0 || s == 3 || s == 4 || s == 5) : seg_enabled(d, s)) &&
          on_seg(px - ox, py - GLYPH_Y, s)) lit = 1'b1;
    end
    return lit ? 12'hfff : 12'h000;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  task automatic fail_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_oldest();
    logic [11:0] exp_rgb;
    logic [11:0] act_rgb;
    string       where;
    if (exp_q.size() > 0) begin
      exp_rgb = exp_q.pop_front();
      where   = name_q.pop_front();
      act_rgb = {red, green, blue};
      assert (act_rgb === exp_rgb) else begin
        $display("Error: %s expected %h actual %h", where, exp_rgb, act_rgb);
        fail_run();
      end
    end
  endtask

  task automatic set_inputs(int px, int py, bit f, bit w, int t, int o);
    x       = px[10:0];
    y       = py[9:0];
    fire    = f;
    warning = w;
    tens    = t[3:0];
    ones    = o[3:0];
    exp_q.push_back(expected_rgb(int'(x), int'(y), f, w, int'(tens), int'(ones)));
    name_q.push_back($sformatf("%s x=%0d y=%0d", test_name, x, y));
  endtask

  // result of the previous pixel is stable here before the next one goes in
  task automatic apply_pixel(int px, int py, bit f, bit w, int t, int o);
    @(posedge clk);
    #2;
    check_oldest();
    set_inputs(px, py, f, w, t, o);
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #2;
      check_oldest();
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("pipeline still held %0d pixels after %0d cycles", exp_q.size(), waited);
      fail_run();
    end
  endtask

  task automatic sweep_window(int x0, bit f, bit w, int t, int o);
    int lx;
    int ly;
    for (ly = 0; ly < 120; ly++) begin
      for (lx = 0; lx < 80; lx++) begin
        apply_pixel(x0 + lx, GLYPH_Y + ly, f, w, t, o);
      end
    end
  endtask

  initial begin
    int i;
    int d;
    void'($urandom(SEED));
    arst_n    = 1'b1;
    fire      = 1'b0;
    warning   = 1'b0;
    tens      = '0;
    ones      = '0;
    x         = '0;
    y         = '0;
    test_name = "reset";
    #1;
    arst_n = 1'b0;  // falling edge clears the colour register before the first clock

    // badge pixels under reset must stay black
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      assert ({red, green, blue} === 12'h000) else begin
        $display("Error: %s expected 000 actual %h", test_name, {red, green, blue});
        fail_run();
      end
      x    = 11'(rand_range(521, 640));
      y    = 10'(rand_range(1, 120));
      fire = 1'b1;
    end
    arst_n = 1'b1;
    set_inputs(0, 0, 0, 0, 0, 0);
    drain_pipeline();

    test_name = "badges";
    for (i = 0; i < 400; i++) begin
      apply_pixel(rand_range(401, 640), rand_range(1, 120), $urandom % 2, $urandom % 2,
                  rand_range(0, 15), rand_range(0, 15));
    end
    for (i = 0; i < 40; i++) begin
      apply_pixel(520 + i % 2, rand_range(1, 120), 1, 1, 0, 0);  // badge boundary
    end
    drain_pipeline();

    test_name = "digits";
    for (d = 0; d < 10; d++) begin
      sweep_window(TENS_X, $urandom % 2, $urandom % 2, d, rand_range(0, 9));
      sweep_window(ONES_X, $urandom % 2, $urandom % 2, rand_range(0, 9), d);
    end
    drain_pipeline();

    test_name = "invalid_digit";
    for (d = 10; d < 16; d++) begin
      for (i = 0; i < 200; i++) begin
        apply_pixel(rand_range(TENS_X, TENS_X + 79), rand_range(GLYPH_Y, GLYPH_Y + 119),
                    0, 0, d, rand_range(0, 9));
        apply_pixel(rand_range(ONES_X, ONES_X + 79), rand_range(GLYPH_Y, GLYPH_Y + 119),
                    0, 0, rand_range(0, 9), d);
      end
    end
    drain_pipeline();

    test_name = "centigrade";
    sweep_window(CELS_X, 1, 1, rand_range(0, 15), rand_range(0, 15));
    for (i = 0; i < 2000; i++) begin
      apply_pixel(rand_range(1, 640), rand_range(1, 480), $urandom % 2, $urandom % 2,
                  rand_range(0, 15), rand_range(0, 15));
    end
    drain_pipeline();

    test_name = "throughput";
    for (i = 0; i < 3000; i++) begin
      apply_pixel($urandom % 2048, $urandom % 1024, $urandom % 2, $urandom % 2,
                  $urandom % 16, $urandom % 16);
    end
    drain_pipeline();

    assert (u_dut.u_overlay_assert.fail_count == 0) else begin
      $display("bound assertions on the DUT failed %0d times",
               u_dut.u_overlay_assert.fail_count);
      fail_run();
    end
    $display("all tests passed");
    $finish;
  end

endmodule

//--- tb/overlay_assert.sv
`timescale 1ns/1ps

module overlay_assert
  import overlay_color_pkg::*;
(
  input logic    i_clk,
  input logic    i_arst_n,
  input region_t i_region,
  input chan_t   i_red,
  input chan_t   i_green,
  input chan_t   i_blue
);

  logic [11:0] rgb;
  int          fail_count = 0;

  assign rgb = {i_red, i_green, i_blue};

  a_no_unknown: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) !$isunknown(rgb)
  ) else begin
    fail_count++;
    $error("colour outputs unknown out of reset");
  end

  // background pixel gives black on the following cycle
  a_black_background: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) (i_region == REG_NONE) |=> (rgb == 12'h000)
  ) else begin
    fail_count++;
    $error("colour not black after a background pixel");
  end

  a_black_in_reset: assert property (
    @(posedge i_clk) !i_arst_n |-> (rgb == 12'h000)
  ) else begin
    fail_count++;
    $error("colour not black while reset is held");
  end

endmodule

bind overlay_top overlay_assert u_overlay_assert (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_region (region),
  .i_red    (o_red),
  .i_green  (o_green),
  .i_blue   (o_blue)
);

//--- design/overlay_top.sv
`timescale 1ns/1ps

module overlay_top
  import overlay_geom_pkg::*, overlay_color_pkg::*;
#(
  parameter int FIRE_X0 = 521,  // fire badge, top right
  parameter int FIRE_Y0 = 1,
  parameter int WARN_X0 = 401,  // warning badge left of it
  parameter int WARN_Y0 = 1,
  parameter int TENS_X0 = 321,
  parameter int TENS_Y0 = 151,
  parameter int ONES_X0 = 401,
  parameter int ONES_Y0 = 151,
  parameter int CELS_X0 = 501,
  parameter int CELS_Y0 = 151
) (
  input  logic   i_clk,
  input  logic   i_arst_n,
  input  logic   i_fire,
  input  logic   i_warning,
  input  digit_t i_tens,
  input  digit_t i_ones,
  input  pix_x_t i_x,
  input  pix_y_t i_y,
  output chan_t  o_red,
  output chan_t  o_green,
  output chan_t  o_blue
);

  region_t   region;
  glyph_x_t  lx;
  glyph_y_t  ly;
  seg_mask_t segs;
  logic      fill;
  logic      lit;

  region_decoder #(
    .FIRE_X0 (FIRE_X0),
    .FIRE_Y0 (FIRE_Y0),
    .WARN_X0 (WARN_X0),
    .WARN_Y0 (WARN_Y0),
    .TENS_X0 (TENS_X0),
    .TENS_Y0 (TENS_Y0),
    .ONES_X0 (ONES_X0),
    .ONES_Y0 (ONES_Y0),
    .CELS_X0 (CELS_X0),
    .CELS_Y0 (CELS_Y0)
  ) u_region_decoder (
    .i_x       (i_x),
    .i_y       (i_y),
    .i_fire    (i_fire),
    .i_warning (i_warning),
    .o_region  (region),
    .o_lx      (lx),
    .o_ly      (ly)
  );

  glyph_select u_glyph_select (
    .i_region (region),
    .i_tens   (i_tens),
    .i_ones   (i_ones),
    .o_segs   (segs),
    .o_fill   (fill)
  );

  seg_painter u_seg_painter (
    .i_lx   (lx),
    .i_ly   (ly),
    .i_segs (segs),
    .o_lit  (lit)
  );

  pixel_composer u_pixel_composer (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_region (region),
    .i_lit    (lit),
    .i_fill   (fill),
    .o_red    (o_red),
    .o_green  (o_green),
    .o_blue   (o_blue)
  );

endmodule

//--- design/pixel_composer.sv
`timescale 1ns/1ps

module pixel_composer
  import overlay_color_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_arst_n,
  input  region_t i_region,
  input  logic    i_lit,
  input  logic    i_fill,
  output chan_t   o_red,
  output chan_t   o_green,
  output chan_t   o_blue
);

  chan_t [2:0] rgb_d;
  chan_t [2:0] rgb_q;

  always_comb begin
    case (i_region)
      REG_FIRE: rgb_d = FIRE_RGB;
      REG_WARN: rgb_d = WARN_RGB;
      REG_TENS, REG_ONES, REG_CELS: begin
        // an invalid digit paints the whole window
        rgb_d = (i_lit || i_fill) ? GLYPH_RGB : BLACK_RGB;
      end
      default: rgb_d = BLACK_RGB;
    endcase
  end

  // the only register in the pipeline, one pixel of latency
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rgb_q <= BLACK_RGB;
    end else begin
      rgb_q <= rgb_d;
    end
  end

  assign o_red   = rgb_q[RGB_R];
  assign o_green = rgb_q[RGB_G];
  assign o_blue  = rgb_q[RGB_B];

endmodule

//--- design/seg_painter.sv
`timescale 1ns/1ps

module seg_painter
  import overlay_geom_pkg::*;
(
  input  glyph_x_t  i_lx,
  input  glyph_y_t  i_ly,
  input  seg_mask_t i_segs,
  output logic      o_lit
);

  seg_mask_t hit;

  // inclusive rectangle test on local offsets
  function automatic logic in_rect(input glyph_x_t x, input glyph_y_t y,
                                   input int x0, input int x1,
                                   input int y0, input int y1);
    in_rect = (int'(x) >= x0) && (int'(x) <= x1) &&
              (int'(y) >= y0) && (int'(y) <= y1);
  endfunction

  // horizontal bars span the full inner width
  always_comb begin
    hit[SEG_A] = in_rect(i_lx, i_ly, COL_L0, COL_END, ROW_T0, ROW_T0 + SEG_T - 1);
    hit[SEG_G] = in_rect(i_lx, i_ly, COL_L0, COL_END, ROW_M0, ROW_M0 + SEG_T - 1);
    hit[SEG_D] = in_rect(i_lx, i_ly, COL_L0, COL_END, ROW_B0, ROW_B0 + SEG_T - 1);
    // upper verticals run from the top bar through the middle bar
    hit[SEG_F] = in_rect(i_lx, i_ly, COL_L0, COL_L0 + SEG_T - 1,
                         ROW_T0, ROW_M0 + SEG_T - 1);
    hit[SEG_B] = in_rect(i_lx, i_ly, COL_R0, COL_END,
                         ROW_T0, ROW_M0 + SEG_T - 1);
    // lower verticals from the middle bar through the bottom bar
    hit[SEG_E] = in_rect(i_lx, i_ly, COL_L0, COL_L0 + SEG_T - 1,
                         ROW_M0, ROW_B0 + SEG_T - 1);
    hit[SEG_C] = in_rect(i_lx, i_ly, COL_R0, COL_END,
                         ROW_M0, ROW_B0 + SEG_T - 1);
  end

  assign o_lit = |(hit & i_segs);  // zero mask outside glyphs keeps this low

endmodule

//--- design/glyph_select.sv
`timescale 1ns/1ps

module glyph_select
  import overlay_geom_pkg::*, overlay_color_pkg::*;
(
  input  region_t   i_region,
  input  digit_t    i_tens,
  input  digit_t    i_ones,
  output seg_mask_t o_segs,
  output logic      o_fill
);

  localparam seg_mask_t CELS_MASK = 7'b011_1001;  // a, d, e, f

  digit_t    digit;
  seg_mask_t digit_segs;

  assign digit = (i_region == REG_TENS) ? i_tens : i_ones;

  // segment order g f e d c b a
  always_comb begin
    case (digit)
      4'd0:    digit_segs = 7'b011_1111;
      4'd1:    digit_segs = 7'b000_0110;
      4'd2:    digit_segs = 7'b101_1011;
      4'd3:    digit_segs = 7'b100_1111;
      4'd4:    digit_segs = 7'b110_0110;
      4'd5:    digit_segs = 7'b110_1101;
      4'd6:    digit_segs = 7'b111_1101;
      4'd7:    digit_segs = 7'b000_0111;
      4'd8:    digit_segs = 7'b111_1111;
      4'd9:    digit_segs = 7'b110_1111;
      default: digit_segs = 7'b000_0000;  // 10..15 go to fill instead
    endcase
  end

  always_comb begin
    o_segs = '0;
    o_fill = 1'b0;
    case (i_region)
      REG_TENS, REG_ONES: begin
        o_segs = digit_segs;
        o_fill = (digit > 4'd9);
      end
      REG_CELS: o_segs = CELS_MASK;
      default: ;  // badges and background carry no glyph
    endcase
  end

endmodule

//--- design/region_decoder.sv
`timescale 1ns/1ps

module region_decoder
  import overlay_geom_pkg::*, overlay_color_pkg::*;
#(
  parameter int FIRE_X0 = 521,
  parameter int FIRE_Y0 = 1,
  parameter int WARN_X0 = 401,
  parameter int WARN_Y0 = 1,
  parameter int TENS_X0 = 321,
  parameter int TENS_Y0 = 151,
  parameter int ONES_X0 = 401,
  parameter int ONES_Y0 = 151,
  parameter int CELS_X0 = 501,
  parameter int CELS_Y0 = 151
) (
  input  pix_x_t   i_x,
  input  pix_y_t   i_y,
  input  logic     i_fire,
  input  logic     i_warning,
  output region_t  o_region,
  output glyph_x_t o_lx,
  output glyph_y_t o_ly
);

  localparam int BADGE_W = 120;  // badges are square
  localparam int BADGE_H = 120;

  pix_x_t dx;
  pix_y_t dy;
  logic   fire_hit;
  logic   warn_hit;
  logic   tens_hit;
  logic   ones_hit;
  logic   cels_hit;

  function automatic logic in_win(input pix_x_t x, input pix_y_t y,
                                  input int x0, input int y0,
                                  input int w, input int h);
    in_win = (int'(x) >= x0) && (int'(x) < x0 + w) &&
             (int'(y) >= y0) && (int'(y) < y0 + h);
  endfunction

  assign fire_hit = in_win(i_x, i_y, FIRE_X0, FIRE_Y0, BADGE_W, BADGE_H);
  assign warn_hit = in_win(i_x, i_y, WARN_X0, WARN_Y0, BADGE_W, BADGE_H);
  assign tens_hit = in_win(i_x, i_y, TENS_X0, TENS_Y0, GLYPH_W, GLYPH_H);
  assign ones_hit = in_win(i_x, i_y, ONES_X0, ONES_Y0, GLYPH_W, GLYPH_H);
  assign cels_hit = in_win(i_x, i_y, CELS_X0, CELS_Y0, GLYPH_W, GLYPH_H);

  // first match wins, badges only count while their alarm is up
  always_comb begin
    o_region = REG_NONE;
    dx       = '0;
    dy       = '0;
    if (i_fire && fire_hit) begin
      o_region = REG_FIRE;
    end else if (i_warning && warn_hit) begin
      o_region = REG_WARN;
    end else if (tens_hit) begin
      o_region = REG_TENS;
      dx       = i_x - pix_x_t'(TENS_X0);
      dy       = i_y - pix_y_t'(TENS_Y0);
    end else if (ones_hit) begin
      o_region = REG_ONES;
      dx       = i_x - pix_x_t'(ONES_X0);
      dy       = i_y - pix_y_t'(ONES_Y0);
    end else if (cels_hit) begin
      o_region = REG_CELS;
      dx       = i_x - pix_x_t'(CELS_X0);
      dy       = i_y - pix_y_t'(CELS_Y0);
    end
  end

  assign o_lx = glyph_x_t'(dx);  // below 80 inside a glyph window
  assign o_ly = glyph_y_t'(dy);  // below 120

endmodule

//--- design/overlay_color_pkg.sv
package overlay_color_pkg;

  typedef logic [3:0] chan_t;

  // which window a pixel belongs to, after priority
  typedef logic [2:0] region_t;

  localparam region_t REG_NONE = 3'd0;
  localparam region_t REG_FIRE = 3'd1;
  localparam region_t REG_WARN = 3'd2;
  localparam region_t REG_TENS = 3'd3;
  localparam region_t REG_ONES = 3'd4;
  localparam region_t REG_CELS = 3'd5;

  // channel triples, index 2 is red, 1 green, 0 blue
  localparam chan_t [2:0] FIRE_RGB  = {4'hf, 4'h0, 4'h0};
  localparam chan_t [2:0] WARN_RGB  = {4'hf, 4'ha, 4'h0};
  localparam chan_t [2:0] GLYPH_RGB = {4'hf, 4'hf, 4'hf};
  localparam chan_t [2:0] BLACK_RGB = {4'h0, 4'h0, 4'h0};

  localparam int RGB_R = 2;
  localparam int RGB_G = 1;
  localparam int RGB_B = 0;

endpackage

//--- design/overlay_geom_pkg.sv
package overlay_geom_pkg;

  // screen coordinates, 1-based from the raster timing block
  typedef logic [10:0] pix_x_t;
  typedef logic [9:0]  pix_y_t;

  // local offsets inside a glyph window
  typedef logic [6:0] glyph_x_t;  // 0..79
  typedef logic [6:0] glyph_y_t;  // 0..119

  typedef logic [3:0] digit_t;    // values above 9 are flagged as invalid

  // bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] seg_mask_t;

  // glyph window size, shared by tens, ones and the centigrade sign
  localparam int GLYPH_W = 80;
  localparam int GLYPH_H = 120;

  localparam int SEG_T = 10;  // segment thickness
  localparam int SEG_M = 10;  // gap between window edge and the outer segments

  // segment indices within seg_mask_t
  localparam int SEG_A = 0;
  localparam int SEG_B = 1;
  localparam int SEG_C = 2;
  localparam int SEG_D = 3;
  localparam int SEG_E = 4;
  localparam int SEG_F = 5;
  localparam int SEG_G = 6;

  // rectangle edges, all inclusive
  localparam int COL_L0 = SEG_M;                    // left bar, 10
  localparam int COL_R0 = GLYPH_W - SEG_M - SEG_T;  // right bar, 60
  localparam int COL_END = GLYPH_W - SEG_M - 1;     // 69
  localparam int ROW_T0 = SEG_M;                    // top bar, 10
  localparam int ROW_M0 = (GLYPH_H - SEG_T) / 2;    // middle bar, 55
  localparam int ROW_B0 = GLYPH_H - SEG_M - SEG_T;  // bottom bar, 100

endpackage
